//--- rtl/ieu_pkg.sv
// shared execution unit definitions; rv32i integer encodings only, no load/store/system opcodes.
package ieu_pkg;

    localparam int DATA_WIDTH  = 32;
    localparam int TAG_WIDTH   = 6;
    localparam int SHAMT_WIDTH = 5;

    typedef logic [DATA_WIDTH-1:0]  ieu_data_t;
    typedef logic [DATA_WIDTH-1:0]  ieu_addr_t;
    typedef logic [TAG_WIDTH-1:0]   ieu_tag_t;
    typedef logic [SHAMT_WIDTH-1:0] ieu_shamt_t;

    typedef enum logic [6:0] {
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_JAL    = 7'b1101111
    } ieu_opcode_t;

    // compares come last so the defined range is contiguous.
    typedef enum logic [3:0] {
        ALU_FUNC_ADD = 4'd0,
        ALU_FUNC_SUB = 4'd1,
        ALU_FUNC_AND = 4'd2,
        ALU_FUNC_OR  = 4'd3,
        ALU_FUNC_XOR = 4'd4,
        ALU_FUNC_SLL = 4'd5,
        ALU_FUNC_SRL = 4'd6,
        ALU_FUNC_SRA = 4'd7,
        ALU_FUNC_EQ  = 4'd8,
        ALU_FUNC_NE  = 4'd9,
        ALU_FUNC_LT  = 4'd10,
        ALU_FUNC_LTU = 4'd11,
        ALU_FUNC_GE  = 4'd12,
        ALU_FUNC_GEU = 4'd13
    } ieu_alu_func_t;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;                    // register form, also carries the shift amount.
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;                    // immediate form.
    } ieu_insn_u;

endpackage

//--- rtl/ieu_id.sv
// decode is purely combinational; unknown opcodes fall back to an add with no jump or branch.
`timescale 1ns/1ns

module ieu_id (
    input  ieu_pkg::ieu_insn_u     i_insn,
    input  ieu_pkg::ieu_addr_t     i_iaddr,
    input  ieu_pkg::ieu_data_t     i_src_a,
    input  ieu_pkg::ieu_data_t     i_src_b,
    input  ieu_pkg::ieu_tag_t      i_tag,
    input  logic                   i_valid,

    output ieu_pkg::ieu_alu_func_t o_alu_func,
    output ieu_pkg::ieu_data_t     o_src_a,
    output ieu_pkg::ieu_data_t     o_src_b,
    output ieu_pkg::ieu_shamt_t    o_shamt,
    output ieu_pkg::ieu_addr_t     o_iaddr,
    output ieu_pkg::ieu_data_t     o_imm_b,
    output logic                   o_jmp,
    output logic                   o_br,
    output logic                   o_valid,
    output ieu_pkg::ieu_tag_t      o_tag
);

    import ieu_pkg::*;

    ieu_data_t  imm_i;
    ieu_data_t  imm_b;
    ieu_data_t  imm_u;
    ieu_data_t  imm_j;
    logic [2:0] funct3;
    logic       bit30;
    logic       is_op;
    logic       is_opimm;
    logic       is_lui;
    logic       is_auipc;
    logic       is_jal;
    logic       is_jalr;
    logic       is_br;

    assign funct3   = i_insn.r.funct3;
    assign bit30    = i_insn.r.funct7[5];

    assign is_op    = i_insn.r.opcode == OPCODE_OP;
    assign is_opimm = i_insn.r.opcode == OPCODE_OPIMM;
    assign is_lui   = i_insn.r.opcode == OPCODE_LUI;
    assign is_auipc = i_insn.r.opcode == OPCODE_AUIPC;
    assign is_jal   = i_insn.r.opcode == OPCODE_JAL;
    assign is_jalr  = i_insn.r.opcode == OPCODE_JALR;
    assign is_br    = i_insn.r.opcode == OPCODE_BRANCH;

    assign imm_i = {{(DATA_WIDTH-12){i_insn.i.imm12[11]}}, i_insn.i.imm12};
    assign imm_b = {{(DATA_WIDTH-12){i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
    assign imm_u = {i_insn[31:12], 12'b0};
    assign imm_j = {{(DATA_WIDTH-20){i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

    assign o_src_a = is_lui               ? '0      :
                     (is_auipc || is_jal) ? i_iaddr :
                                            i_src_a;

    assign o_src_b = (is_opimm || is_jalr) ? imm_i :
                     is_jal                ? imm_j :
                     (is_lui || is_auipc)  ? imm_u :
                                             i_src_b;

    assign o_shamt = is_op ? i_src_b[SHAMT_WIDTH-1:0] : i_insn.r.rs2;
    assign o_iaddr = i_iaddr;
    assign o_imm_b = imm_b;
    assign o_tag   = i_tag;
    assign o_valid = i_valid;
    assign o_jmp   = is_jal | is_jalr;
    assign o_br    = is_br & (funct3 != 3'b010) & (funct3 != 3'b011); // no such branches.

    always_comb begin
        o_alu_func = ALU_FUNC_ADD; // lui, auipc and jumps use the adder.
        if (is_br) begin
            case (funct3)
                3'b000:  o_alu_func = ALU_FUNC_EQ;
                3'b001:  o_alu_func = ALU_FUNC_NE;
                3'b100:  o_alu_func = ALU_FUNC_LT;
                3'b101:  o_alu_func = ALU_FUNC_GE;
                3'b110:  o_alu_func = ALU_FUNC_LTU;
                3'b111:  o_alu_func = ALU_FUNC_GEU;
                default: o_alu_func = ALU_FUNC_ADD;
            endcase
        end else if (is_op || is_opimm) begin
            case (funct3)
                3'b000: o_alu_func = (is_op && bit30) ? ALU_FUNC_SUB : ALU_FUNC_ADD;
                3'b001: o_alu_func = ALU_FUNC_SLL;
                3'b010: o_alu_func = ALU_FUNC_LT;
                3'b011: o_alu_func = ALU_FUNC_LTU;
                3'b100: o_alu_func = ALU_FUNC_XOR;
                3'b101: o_alu_func = bit30 ? ALU_FUNC_SRA : ALU_FUNC_SRL; // srai too.
                3'b110: o_alu_func = ALU_FUNC_OR;
                3'b111: o_alu_func = ALU_FUNC_AND;
            endcase
        end
    end

endmodule

//--- rtl/ieu_alu.sv
// execute stage; operands are captured on every clock whether or not the slot is valid.
`timescale 1ns/1ns

module ieu_alu (
    input  logic                   clk,
    input  ieu_pkg::ieu_alu_func_t i_alu_func,
    input  ieu_pkg::ieu_data_t     i_src_a,
    input  ieu_pkg::ieu_data_t     i_src_b,
    input  ieu_pkg::ieu_shamt_t    i_shamt,
    input  ieu_pkg::ieu_addr_t     i_iaddr,
    input  ieu_pkg::ieu_data_t     i_imm_b,

    output ieu_pkg::ieu_data_t     o_result,
    output logic                   o_cmp,
    output ieu_pkg::ieu_addr_t     o_iaddr,
    output ieu_pkg::ieu_data_t     o_imm_b
);

    import ieu_pkg::*;

    ieu_alu_func_t alu_func;
    ieu_data_t     src_a;
    ieu_data_t     src_b;
    ieu_shamt_t    shamt;
    logic          cmp_eq;
    logic          cmp_lt;
    logic          cmp_ltu;

    always_ff @(posedge clk) begin
        alu_func <= i_alu_func;
        src_a    <= i_src_a;
        src_b    <= i_src_b;
        shamt    <= i_shamt;
        o_iaddr  <= i_iaddr;
        o_imm_b  <= i_imm_b;
    end

    assign cmp_eq  = src_a == src_b;
    assign cmp_lt  = $signed(src_a) < $signed(src_b);
    assign cmp_ltu = src_a < src_b;

    always_comb begin
        case (alu_func)
            ALU_FUNC_ADD: o_result = src_a + src_b;
            ALU_FUNC_SUB: o_result = src_a - src_b;
            ALU_FUNC_AND: o_result = src_a & src_b;
            ALU_FUNC_OR:  o_result = src_a | src_b;
            ALU_FUNC_XOR: o_result = src_a ^ src_b;
            ALU_FUNC_SLL: o_result = src_a << shamt;
            ALU_FUNC_SRL: o_result = src_a >> shamt;
            ALU_FUNC_SRA: o_result = $signed(src_a) >>> shamt;
            ALU_FUNC_EQ:  o_result = {{(DATA_WIDTH-1){1'b0}}, cmp_eq};
            ALU_FUNC_NE:  o_result = {{(DATA_WIDTH-1){1'b0}}, ~cmp_eq};
            ALU_FUNC_LT:  o_result = {{(DATA_WIDTH-1){1'b0}}, cmp_lt};
            ALU_FUNC_LTU: o_result = {{(DATA_WIDTH-1){1'b0}}, cmp_ltu};
            ALU_FUNC_GE:  o_result = {{(DATA_WIDTH-1){1'b0}}, ~cmp_lt};
            ALU_FUNC_GEU: o_result = {{(DATA_WIDTH-1){1'b0}}, ~cmp_ltu};
            default:      o_result = '0;
        endcase
    end

    assign o_cmp = o_result[0]; // branch condition.

    // decode must only ever hand over one of the fourteen functions.
    assert property (@(posedge clk)
        !$isunknown(alu_func) |-> alu_func inside {[ALU_FUNC_ADD:ALU_FUNC_GEU]})
        else $error("ieu_alu: undefined alu function %0d", alu_func);

endmodule

//--- rtl/ieu_wb.sv
// writeback data and redirect address; both are meaningful only while the control valid is high.
`timescale 1ns/1ns

module ieu_wb (
    input  logic               clk,
    input  ieu_pkg::ieu_data_t i_result,
    input  ieu_pkg::ieu_addr_t i_iaddr,
    input  ieu_pkg::ieu_data_t i_imm_b,
    input  logic               i_jmp,
    input  logic               i_redirect_jmp,

    output ieu_pkg::ieu_data_t o_data,
    output ieu_pkg::ieu_addr_t o_redirect_addr
);

    import ieu_pkg::*;

    ieu_addr_t ret_addr;
    ieu_addr_t br_target;
    ieu_addr_t jmp_target;

    assign ret_addr   = i_iaddr + ieu_addr_t'(4);
    assign br_target  = i_iaddr + i_imm_b;
    assign jmp_target = {i_result[DATA_WIDTH-1:1], 1'b0}; // jalr clears bit 0.

    always_ff @(posedge clk) begin
        o_data          <= i_jmp ? ret_addr : i_result;
        o_redirect_addr <= i_redirect_jmp ? jmp_target : br_target;
    end

endmodule

//--- rtl/ieu_ctrl.sv
// control pipeline; a redirect is only raised in the same cycle as its valid.
`timescale 1ns/1ns

module ieu_ctrl (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_valid,
    input  ieu_pkg::ieu_tag_t i_tag,
    input  logic              i_jmp,
    input  logic              i_br,
    input  logic              i_cmp,

    output logic              o_ex_jmp,
    output logic              o_valid,
    output ieu_pkg::ieu_tag_t o_tag,
    output logic              o_redirect
);

    import ieu_pkg::*;

    logic     ex_valid;
    ieu_tag_t ex_tag;
    logic     ex_br;
    logic     redirect;

    assign redirect = ex_valid & (o_ex_jmp | (ex_br & i_cmp));

    // execute stage.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ex_valid <= 1'b0;
            ex_tag   <= '0;
            o_ex_jmp <= 1'b0;
            ex_br    <= 1'b0;
        end else begin
            ex_valid <= i_valid;
            ex_tag   <= i_tag;
            o_ex_jmp <= i_valid & i_jmp; // flags only for real slots.
            ex_br    <= i_valid & i_br;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid    <= 1'b0;
            o_tag      <= '0;
            o_redirect <= 1'b0;
        end else begin
            o_valid    <= ex_valid;
            o_tag      <= ex_tag;
            o_redirect <= redirect;
        end
    end

    assert property (@(posedge clk) disable iff (i_reset) !(o_ex_jmp && ex_br))
        else $error("ieu_ctrl: jump and branch both decoded");

    assert property (@(posedge clk) disable iff (i_reset) o_redirect |-> o_valid)
        else $error("ieu_ctrl: redirect without valid");

endmodule

//--- rtl/ieu_top.sv
// two-cycle integer execution unit; no back-pressure, results must be taken when o_valid is high.
`timescale 1ns/1ns

module ieu_top (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_valid,
    input  ieu_pkg::ieu_insn_u i_insn,
    input  ieu_pkg::ieu_addr_t i_iaddr,
    input  ieu_pkg::ieu_data_t i_src_a,
    input  ieu_pkg::ieu_data_t i_src_b,
    input  ieu_pkg::ieu_tag_t  i_tag,

    output logic               o_valid,
    output ieu_pkg::ieu_tag_t  o_tag,
    output ieu_pkg::ieu_data_t o_data,
    output logic               o_redirect,
    output ieu_pkg::ieu_addr_t o_redirect_addr
);

    import ieu_pkg::*;

    ieu_alu_func_t id_alu_func;
    ieu_data_t     id_src_a;
    ieu_data_t     id_src_b;
    ieu_shamt_t    id_shamt;
    ieu_addr_t     id_iaddr;
    ieu_data_t     id_imm_b;
    logic          id_jmp;
    logic          id_br;
    logic          id_valid;
    ieu_tag_t      id_tag;
    ieu_data_t     ex_result;
    logic          ex_cmp;
    ieu_addr_t     ex_iaddr;
    ieu_data_t     ex_imm_b;
    logic          ex_jmp;

    ieu_id ieu_id_inst (
        .i_insn(i_insn), .i_iaddr(i_iaddr), .i_src_a(i_src_a), .i_src_b(i_src_b),
        .i_tag(i_tag), .i_valid(i_valid),
        .o_alu_func(id_alu_func), .o_src_a(id_src_a), .o_src_b(id_src_b),
        .o_shamt(id_shamt), .o_iaddr(id_iaddr), .o_imm_b(id_imm_b),
        .o_jmp(id_jmp), .o_br(id_br), .o_valid(id_valid), .o_tag(id_tag)
    );

    ieu_alu ieu_alu_inst (
        .clk(clk), .i_alu_func(id_alu_func), .i_src_a(id_src_a), .i_src_b(id_src_b),
        .i_shamt(id_shamt), .i_iaddr(id_iaddr), .i_imm_b(id_imm_b),
        .o_result(ex_result), .o_cmp(ex_cmp), .o_iaddr(ex_iaddr), .o_imm_b(ex_imm_b)
    );

    // jump flag picks both the return address and the jump target.
    ieu_wb ieu_wb_inst (
        .clk(clk), .i_result(ex_result), .i_iaddr(ex_iaddr), .i_imm_b(ex_imm_b),
        .i_jmp(ex_jmp), .i_redirect_jmp(ex_jmp),
        .o_data(o_data), .o_redirect_addr(o_redirect_addr)
    );

    ieu_ctrl ieu_ctrl_inst (
        .clk(clk), .i_reset(i_reset), .i_valid(id_valid), .i_tag(id_tag),
        .i_jmp(id_jmp), .i_br(id_br), .i_cmp(ex_cmp),
        .o_ex_jmp(ex_jmp), .o_valid(o_valid), .o_tag(o_tag), .o_redirect(o_redirect)
    );

endmodule

//--- dv/ieu_model.svh
// reference model of the execution unit; needs ieu_pkg imported by the including module.
`ifndef IEU_MODEL_SVH
`define IEU_MODEL_SVH

function automatic ieu_data_t imm_i_of(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
endfunction

function automatic ieu_data_t imm_b_of(input logic [31:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic ieu_data_t imm_u_of(input logic [31:0] w);
    return {w[31:12], 12'h000};
endfunction

function automatic ieu_data_t imm_j_of(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

// branch condition from funct3; reserved encodings never take.
function automatic logic branch_taken(input logic [31:0] w, input ieu_data_t a, input ieu_data_t b);
    case (w[14:12])
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic ieu_data_t expected_data(input logic [31:0] w, input ieu_addr_t pc,
                                            input ieu_data_t a, input ieu_data_t b);
    ieu_data_t  rhs;
    logic [4:0] sh;
    logic       is_reg;
    is_reg = w[6:0] == OPCODE_OP;
    rhs    = is_reg ? b : imm_i_of(w);
    sh     = is_reg ? b[4:0] : w[24:20];
    case (w[6:0])
        OPCODE_LUI:   return imm_u_of(w);
        OPCODE_AUIPC: return pc + imm_u_of(w);
        OPCODE_JAL,
        OPCODE_JALR:  return pc + 32'd4;
        OPCODE_BRANCH: begin
            if (w[14:13] == 2'b01) return a + b; // no compare, plain adder.
            return {31'd0, branch_taken(w, a, b)};
        end
        default: begin
            case (w[14:12])
                3'b000:  return (is_reg && w[30]) ? a - rhs : a + rhs;
                3'b001:  return a << sh;
                3'b010:  return {31'd0, $signed(a) < $signed(rhs)};
                3'b011:  return {31'd0, a < rhs};
                3'b100:  return a ^ rhs;
                3'b101:  return w[30] ? ieu_data_t'($signed(a) >>> sh) : a >> sh;
                3'b110:  return a | rhs;
                default: return a & rhs;
            endcase
        end
    endcase
endfunction

function automatic logic expected_redirect(input logic [31:0] w, input ieu_data_t a,
                                           input ieu_data_t b);
    if (w[6:0] == OPCODE_JAL || w[6:0] == OPCODE_JALR) return 1'b1;
    if (w[6:0] == OPCODE_BRANCH) return branch_taken(w, a, b);
    return 1'b0;
endfunction

function automatic ieu_addr_t expected_target(input logic [31:0] w, input ieu_addr_t pc,
                                              input ieu_data_t a);
    if (w[6:0] == OPCODE_JAL) return pc + imm_j_of(w);
    if (w[6:0] == OPCODE_JALR) return (a + imm_i_of(w)) & ~32'd1;
    return pc + imm_b_of(w);
endfunction

`endif

//--- dv/ieu_tb.sv
// random testbench for ieu_top; inputs change on the falling edge, outputs checked there too.
`timescale 1ns/1ns

module ieu_tb;

    import ieu_pkg::*;

    `include "ieu_model.svh"

    localparam int N_DIR   = 40;  // per directed class.
    localparam int N_MIX   = 400;
    localparam int MAX_GAP = 3;
    localparam int LIMIT   = 3 + 5 + 5 * N_DIR + N_MIX * (MAX_GAP + 1) + 4 + 2 + 20;

    logic      clk;
    logic      i_reset;
    logic      i_valid;
    ieu_insn_u i_insn;
    ieu_addr_t i_iaddr;
    ieu_data_t i_src_a;
    ieu_data_t i_src_b;
    ieu_tag_t  i_tag;
    logic      o_valid;
    ieu_tag_t  o_tag;
    ieu_data_t o_data;
    logic      o_redirect;
    ieu_addr_t o_redirect_addr;

    integer    seed = 87;
    int        cycle = 0;
    ieu_data_t exp_data[$];
    logic      exp_redir[$];
    ieu_addr_t exp_addr[$];
    ieu_tag_t  exp_tag[$];
    int        exp_cycle[$];

    ieu_top UUT (
        .clk(clk), .i_reset(i_reset), .i_valid(i_valid), .i_insn(i_insn),
        .i_iaddr(i_iaddr), .i_src_a(i_src_a), .i_src_b(i_src_b), .i_tag(i_tag),
        .o_valid(o_valid), .o_tag(o_tag), .o_data(o_data),
        .o_redirect(o_redirect), .o_redirect_addr(o_redirect_addr)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > LIMIT) begin
            $display("timeout after %0d cycles, outputs stopped arriving", cycle);
            $display("Finished with errors");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    // compares the outputs seen after the last rising edge with the queue front.
    task automatic check_outputs();
        logic redir;
        if (!o_valid) begin
            check_value("idle redirect", 32'd0, {31'd0, o_redirect});
        end else if (exp_tag.size() == 0) begin
            $display("o_valid was high with no instruction in flight");
            $display("Finished with errors");
            $fatal(1, "unexpected output");
        end else begin
            redir = exp_redir.pop_front();
            check_value("latency", exp_cycle.pop_front(), cycle);
            check_value("tag", {26'd0, exp_tag.pop_front()}, {26'd0, o_tag});
            check_value("data", exp_data.pop_front(), o_data);
            check_value("redirect", {31'd0, redir}, {31'd0, o_redirect});
            if (redir)
                check_value("redirect addr", exp_addr.pop_front(), o_redirect_addr);
            else
                void'(exp_addr.pop_front());
        end
    endtask

    // kind 0 op, 1 opimm, 2 lui/auipc, 3 jal/jalr, 4 branch, 5 any of them.
    function automatic ieu_insn_u make_insn(input int kind);
        ieu_insn_u w;
        logic [31:0] r;
        int k;
        w = rand32();
        r = rand32();
        k = (kind == 5) ? int'(r[2:0]) % 5 : kind;
        case (k)
            0: begin
                w.r.funct7 = {1'b0, r[8], 5'b0};
                w.r.opcode = OPCODE_OP;
            end
            1: w.i.opcode = OPCODE_OPIMM;
            2: w.r.opcode = r[9] ? OPCODE_LUI : OPCODE_AUIPC;
            3: w.i.opcode = r[9] ? OPCODE_JAL : OPCODE_JALR;
            default: w.r.opcode = OPCODE_BRANCH;
        endcase
        return w;
    endfunction

    task automatic step(input logic valid, input int kind);
        logic [31:0] r;
        @(negedge clk);
        check_outputs();
        r       = rand32();
        i_valid = valid;
        i_insn  = make_insn(kind);
        i_iaddr = {r[31:2], 2'b00};
        i_src_a = rand32();
        i_src_b = (r[1:0] == 2'b00) ? i_src_a : rand32(); // equal operands for branches.
        i_tag   = r[7:2];
        if (valid) begin
            exp_data.push_back(expected_data(i_insn, i_iaddr, i_src_a, i_src_b));
            exp_redir.push_back(expected_redirect(i_insn, i_src_a, i_src_b));
            exp_addr.push_back(expected_target(i_insn, i_iaddr, i_src_a));
            exp_tag.push_back(i_tag);
            exp_cycle.push_back(cycle + 2);
        end
    endtask

    initial begin
        logic [31:0] r;
        clk     = 1'b0;
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_insn  = '0;
        i_iaddr = '0;
        i_src_a = '0;
        i_src_b = '0;
        i_tag   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        repeat (5) step(1'b0, 0);
        for (int kind = 0; kind < 5; kind++)
            repeat (N_DIR) step(1'b1, kind);
        repeat (N_MIX) begin
            r = rand32();
            repeat (int'(r[1:0])) step(1'b0, 5);
            step(1'b1, 5);
        end
        repeat (4) step(1'b0, 5);
        if (exp_tag.size() != 0) begin
            $display("%0d instructions never came out", exp_tag.size());
            $display("Finished with errors");
            $fatal(1, "leftover instructions");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+dv
rtl/ieu_pkg.sv
rtl/ieu_id.sv
rtl/ieu_alu.sv
rtl/ieu_wb.sv
rtl/ieu_ctrl.sv
rtl/ieu_top.sv
dv/ieu_tb.sv

//--- run.sh
#!/bin/sh
# builds the execution unit testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module ieu_tb -o ieu_sim \
    && ./obj_dir/ieu_sim \
    || exit 1
